// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // ==================================================
    // Opcodes
    // ==================================================
    localparam int OPCODE_WIDTH = 8;

    typedef logic [OPCODE_WIDTH-1:0] opcode_t;

    // Control flow
    localparam opcode_t NOP = 8'h00, HLT = 8'h01, JMP = 8'h02;
    localparam opcode_t JZ = 8'h03, JNZ = 8'h04, JC = 8'h05, JNC = 8'h06;
    localparam opcode_t JN = 8'h07, JNN = 8'h08;

    // Arithmetic on A
    localparam opcode_t ADD_B = 8'h09, ADD_C = 8'h0A, ADC_B = 8'h0B, ADC_C = 8'h0C;
    localparam opcode_t SUB_B = 8'h0D, SUB_C = 8'h0E, SBC_B = 8'h0F, SBC_C = 8'h10;
    localparam opcode_t INR_A = 8'h11, DCR_A = 8'h12;

    // Logic, register or immediate
    localparam opcode_t ANA_B = 8'h13, ANA_C = 8'h14, ANI = 8'h15;
    localparam opcode_t ORA_B = 8'h16, ORA_C = 8'h17, ORI = 8'h18;
    localparam opcode_t XRA_B = 8'h19, XRA_C = 8'h1A, XRI = 8'h1B;
    localparam opcode_t CMP_B = 8'h1C, CMP_C = 8'h1D;

    // B and C inc/dec
    localparam opcode_t INR_B = 8'h1E, DCR_B = 8'h1F, INR_C = 8'h20, DCR_C = 8'h21;

    // Moves and immediate loads
    localparam opcode_t MOV_AB = 8'h22, MOV_AC = 8'h23, MOV_BA = 8'h24;
    localparam opcode_t MOV_BC = 8'h25, MOV_CA = 8'h26, MOV_CB = 8'h27;
    localparam opcode_t LDI_A = 8'h28, LDI_B = 8'h29, LDI_C = 8'h2A;

    // Carry and memory
    localparam opcode_t SEC = 8'h2B, CLC = 8'h2C, LDA = 8'h2D, STA = 8'h2E;

    // ==================================================
    // ALU and flags
    // ==================================================
    typedef enum logic [3:0] {
        ALU_UNDEFINED,
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_INR,
        ALU_DCR,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    localparam int FLAGS_WIDTH = 3;

    typedef logic [FLAGS_WIDTH-1:0] flags_t;

    localparam int FLAG_ZERO  = 0;
    localparam int FLAG_CARRY = 1;
    localparam int FLAG_NEG   = 2;

endpackage

// ==== hw/ctrl_pkg.sv ====
package ctrl_pkg;

    // ==================================================
    // Control word layout
    // ==================================================
    localparam int CW_WIDTH = 29;

    typedef logic [CW_WIDTH-1:0] control_word_t;

    localparam int CW_LOAD_ORIGIN   = 0;   // Reset vector into PC
    localparam int CW_LOAD_MAR_PC   = 1;
    localparam int CW_OE_RAM        = 2;
    localparam int CW_PC_ENABLE     = 3;
    localparam int CW_LOAD_IR       = 4;
    localparam int CW_LOAD_TEMP_1   = 5;
    localparam int CW_LOAD_TEMP_2   = 6;
    localparam int CW_OE_TEMP_1     = 7;
    localparam int CW_OE_TEMP_2     = 8;
    localparam int CW_LOAD_PC_LOW   = 9;
    localparam int CW_LOAD_PC_HIGH  = 10;
    localparam int CW_LOAD_MAR_LOW  = 11;
    localparam int CW_LOAD_MAR_HIGH = 12;
    localparam int CW_LOAD_RAM      = 13;
    localparam int CW_OE_ALU        = 14;
    localparam int CW_OE_A          = 15;
    localparam int CW_OE_B          = 16;
    localparam int CW_OE_C          = 17;
    localparam int CW_LOAD_A        = 18;
    localparam int CW_LOAD_B        = 19;
    localparam int CW_LOAD_C        = 20;
    localparam int CW_LOAD_STATUS   = 21;
    localparam int CW_LOAD_SETS_ZN  = 22;  // Status from bus value, Z and N only
    localparam int CW_SRC1_B        = 23;
    localparam int CW_SRC1_C        = 24;
    localparam int CW_SRC2_C        = 25;
    localparam int CW_SRC2_TEMP1    = 26;
    localparam int CW_SET_CARRY     = 27;
    localparam int CW_CLEAR_CARRY   = 28;

    // ==================================================
    // Sequencer
    // ==================================================
    localparam int MICROSTEP_WIDTH = 3;

    typedef logic [MICROSTEP_WIDTH-1:0] microstep_t;
    typedef logic [1:0] byte_count_t;

    typedef enum logic [2:0] {
        COND_NONE,
        COND_ZERO,
        COND_NOT_ZERO,
        COND_CARRY,
        COND_NOT_CARRY,
        COND_NEG,
        COND_NOT_NEG
    } branch_cond_t;

    typedef enum logic [2:0] {
        S_RESET,
        S_INIT,
        S_LATCH_ADDR,
        S_READ_BYTE,
        S_LATCH_BYTE,
        S_CHK_MORE_BYTES,
        S_EXECUTE,
        S_HALT
    } seq_state_t;

endpackage

// ==== hw/decode_rom.sv ====
`timescale 1ns/1ns

module decode_rom (
    input  isa_pkg::opcode_t          opcode,
    input  ctrl_pkg::microstep_t      microstep,
    output ctrl_pkg::control_word_t   rom_word,
    output isa_pkg::alu_op_t          rom_alu_op,
    output ctrl_pkg::branch_cond_t    rom_cond,
    output logic                      rom_halt,
    output logic                      rom_last,
    output ctrl_pkg::byte_count_t     operand_bytes
);

    isa_pkg::alu_op_t alu_sel;    // ALU op of the opcode, UNDEFINED if not an ALU instr
    logic alu_imm;
    logic alu_to_b;
    logic alu_to_c;
    logic alu_src2_c;
    logic alu_cmp;
    logic alu_writes;
    logic mem_read;

    always_comb begin
        case (opcode)
            isa_pkg::ADD_B, isa_pkg::ADD_C: alu_sel = isa_pkg::ALU_ADD;
            isa_pkg::ADC_B, isa_pkg::ADC_C: alu_sel = isa_pkg::ALU_ADC;
            isa_pkg::SUB_B, isa_pkg::SUB_C,
            isa_pkg::CMP_B, isa_pkg::CMP_C: alu_sel = isa_pkg::ALU_SUB;
            isa_pkg::SBC_B, isa_pkg::SBC_C: alu_sel = isa_pkg::ALU_SBC;
            isa_pkg::INR_A, isa_pkg::INR_B, isa_pkg::INR_C: alu_sel = isa_pkg::ALU_INR;
            isa_pkg::DCR_A, isa_pkg::DCR_B, isa_pkg::DCR_C: alu_sel = isa_pkg::ALU_DCR;
            isa_pkg::ANA_B, isa_pkg::ANA_C, isa_pkg::ANI: alu_sel = isa_pkg::ALU_AND;
            isa_pkg::ORA_B, isa_pkg::ORA_C, isa_pkg::ORI: alu_sel = isa_pkg::ALU_OR;
            isa_pkg::XRA_B, isa_pkg::XRA_C, isa_pkg::XRI: alu_sel = isa_pkg::ALU_XOR;
            default: alu_sel = isa_pkg::ALU_UNDEFINED;
        endcase
    end

    assign alu_imm    = opcode inside {isa_pkg::ANI, isa_pkg::ORI, isa_pkg::XRI};
    assign alu_to_b   = opcode inside {isa_pkg::INR_B, isa_pkg::DCR_B};
    assign alu_to_c   = opcode inside {isa_pkg::INR_C, isa_pkg::DCR_C};
    assign alu_cmp    = opcode inside {isa_pkg::CMP_B, isa_pkg::CMP_C};
    assign alu_src2_c = opcode inside {isa_pkg::ADD_C, isa_pkg::ADC_C, isa_pkg::SUB_C,
                                       isa_pkg::SBC_C, isa_pkg::ANA_C, isa_pkg::ORA_C,
                                       isa_pkg::XRA_C, isa_pkg::CMP_C};
    // ADD_B writes A in step 1 and the status in step 2
    assign alu_writes = !alu_cmp && !(opcode == isa_pkg::ADD_B && microstep == 3'd2);
    assign mem_read   = (opcode == isa_pkg::LDA);

    // ==================================================
    // Microcode
    // ==================================================
    always_comb begin
        rom_word   = '0;
        rom_alu_op = isa_pkg::ALU_UNDEFINED;
        rom_cond   = ctrl_pkg::COND_NONE;
        rom_halt   = 1'b0;
        rom_last   = 1'b0;
        case (opcode)
            isa_pkg::NOP: rom_last = 1'b1;
            isa_pkg::HLT: rom_halt = 1'b1;
            isa_pkg::JMP, isa_pkg::JZ, isa_pkg::JNZ, isa_pkg::JC,
            isa_pkg::JNC, isa_pkg::JN, isa_pkg::JNN: begin
                if (microstep == 3'd0) begin      // Low byte, condition tested here
                    rom_word[ctrl_pkg::CW_OE_TEMP_1]   = 1'b1;
                    rom_word[ctrl_pkg::CW_LOAD_PC_LOW] = 1'b1;
                    case (opcode)
                        isa_pkg::JZ:  rom_cond = ctrl_pkg::COND_ZERO;
                        isa_pkg::JNZ: rom_cond = ctrl_pkg::COND_NOT_ZERO;
                        isa_pkg::JC:  rom_cond = ctrl_pkg::COND_CARRY;
                        isa_pkg::JNC: rom_cond = ctrl_pkg::COND_NOT_CARRY;
                        isa_pkg::JN:  rom_cond = ctrl_pkg::COND_NEG;
                        isa_pkg::JNN: rom_cond = ctrl_pkg::COND_NOT_NEG;
                        default:      rom_cond = ctrl_pkg::COND_NONE;
                    endcase
                end else begin
                    rom_word[ctrl_pkg::CW_OE_TEMP_2]    = 1'b1;
                    rom_word[ctrl_pkg::CW_LOAD_PC_HIGH] = 1'b1;
                    rom_last = 1'b1;
                end
            end
            isa_pkg::MOV_AB, isa_pkg::MOV_AC, isa_pkg::MOV_BA,
            isa_pkg::MOV_BC, isa_pkg::MOV_CA, isa_pkg::MOV_CB: begin
                rom_word[ctrl_pkg::CW_OE_A]   = opcode inside {isa_pkg::MOV_AB, isa_pkg::MOV_AC};
                rom_word[ctrl_pkg::CW_OE_B]   = opcode inside {isa_pkg::MOV_BA, isa_pkg::MOV_BC};
                rom_word[ctrl_pkg::CW_OE_C]   = opcode inside {isa_pkg::MOV_CA, isa_pkg::MOV_CB};
                rom_word[ctrl_pkg::CW_LOAD_A] = opcode inside {isa_pkg::MOV_BA, isa_pkg::MOV_CA};
                rom_word[ctrl_pkg::CW_LOAD_B] = opcode inside {isa_pkg::MOV_AB, isa_pkg::MOV_CB};
                rom_word[ctrl_pkg::CW_LOAD_C] = opcode inside {isa_pkg::MOV_AC, isa_pkg::MOV_BC};
                rom_last = 1'b1;
            end
            isa_pkg::LDI_A, isa_pkg::LDI_B, isa_pkg::LDI_C: begin
                rom_word[ctrl_pkg::CW_OE_TEMP_1]    = 1'b1;
                rom_word[ctrl_pkg::CW_LOAD_A]       = (opcode == isa_pkg::LDI_A);
                rom_word[ctrl_pkg::CW_LOAD_B]       = (opcode == isa_pkg::LDI_B);
                rom_word[ctrl_pkg::CW_LOAD_C]       = (opcode == isa_pkg::LDI_C);
                rom_word[ctrl_pkg::CW_LOAD_STATUS]  = 1'b1;
                rom_word[ctrl_pkg::CW_LOAD_SETS_ZN] = 1'b1;
                rom_last = 1'b1;
            end
            isa_pkg::SEC, isa_pkg::CLC: begin
                rom_word[ctrl_pkg::CW_SET_CARRY]   = (opcode == isa_pkg::SEC);
                rom_word[ctrl_pkg::CW_CLEAR_CARRY] = (opcode == isa_pkg::CLC);
                rom_word[ctrl_pkg::CW_LOAD_STATUS] = 1'b1;
                rom_last = 1'b1;
            end
            isa_pkg::LDA, isa_pkg::STA: begin
                // Address low, address high, then two data cycles
                rom_word[ctrl_pkg::CW_OE_TEMP_1]     = (microstep < 3'd2);
                rom_word[ctrl_pkg::CW_LOAD_MAR_LOW]  = (microstep == 3'd1);
                rom_word[ctrl_pkg::CW_OE_TEMP_2]     = microstep inside {3'd2, 3'd3};
                rom_word[ctrl_pkg::CW_LOAD_MAR_HIGH] = (microstep == 3'd3);
                rom_word[ctrl_pkg::CW_OE_RAM]        = mem_read && microstep >= 3'd4;
                rom_word[ctrl_pkg::CW_OE_A]          = !mem_read && microstep >= 3'd4;
                rom_last = (microstep == 3'd5);
                rom_word[ctrl_pkg::CW_LOAD_A]       = mem_read && rom_last;
                rom_word[ctrl_pkg::CW_LOAD_STATUS]  = mem_read && rom_last;
                rom_word[ctrl_pkg::CW_LOAD_SETS_ZN] = mem_read && rom_last;
                rom_word[ctrl_pkg::CW_LOAD_RAM]     = !mem_read && rom_last;
            end
            default: begin
                if (alu_sel == isa_pkg::ALU_UNDEFINED) begin
                    rom_halt = 1'b1;    // Unknown opcode stops like HLT
                end else if (microstep == 3'd0) begin
                    rom_alu_op = alu_sel;
                    rom_word[ctrl_pkg::CW_OE_TEMP_1]  = alu_imm;
                    rom_word[ctrl_pkg::CW_SRC2_TEMP1] = alu_imm;
                    rom_word[ctrl_pkg::CW_SRC2_C]     = alu_src2_c;
                    rom_word[ctrl_pkg::CW_SRC1_B]     = alu_to_b;
                    rom_word[ctrl_pkg::CW_SRC1_C]     = alu_to_c;
                end else begin
                    rom_word[ctrl_pkg::CW_OE_ALU] = alu_writes;
                    rom_word[ctrl_pkg::CW_LOAD_A] = alu_writes && !alu_to_b && !alu_to_c;
                    rom_word[ctrl_pkg::CW_LOAD_B] = alu_writes && alu_to_b;
                    rom_word[ctrl_pkg::CW_LOAD_C] = alu_writes && alu_to_c;
                    rom_last = !(opcode == isa_pkg::ADD_B && microstep == 3'd1);
                    rom_word[ctrl_pkg::CW_LOAD_STATUS] = rom_last;
                end
            end
        endcase
    end

    // Operand bytes following the opcode
    always_comb begin
        case (opcode)
            isa_pkg::LDI_A, isa_pkg::LDI_B, isa_pkg::LDI_C,
            isa_pkg::ANI, isa_pkg::ORI, isa_pkg::XRI: operand_bytes = 2'd1;
            isa_pkg::JMP, isa_pkg::JZ, isa_pkg::JNZ, isa_pkg::JC, isa_pkg::JNC,
            isa_pkg::JN, isa_pkg::JNN, isa_pkg::LDA, isa_pkg::STA: operand_bytes = 2'd2;
            default: operand_bytes = 2'd0;
        endcase
    end

endmodule

// ==== hw/branch_eval.sv ====
`timescale 1ns/1ns

module branch_eval (
    input  ctrl_pkg::branch_cond_t cond,
    input  isa_pkg::flags_t        flags,
    output logic                   branch_skip
);

    // Skip when the named flag does not hold the required value
    always_comb begin
        case (cond)
            ctrl_pkg::COND_ZERO:      branch_skip = !flags[isa_pkg::FLAG_ZERO];
            ctrl_pkg::COND_NOT_ZERO:  branch_skip = flags[isa_pkg::FLAG_ZERO];
            ctrl_pkg::COND_CARRY:     branch_skip = !flags[isa_pkg::FLAG_CARRY];
            ctrl_pkg::COND_NOT_CARRY: branch_skip = flags[isa_pkg::FLAG_CARRY];
            ctrl_pkg::COND_NEG:       branch_skip = !flags[isa_pkg::FLAG_NEG];
            ctrl_pkg::COND_NOT_NEG:   branch_skip = flags[isa_pkg::FLAG_NEG];
            default:                  branch_skip = 1'b0;   // COND_NONE, always taken
        endcase
    end

endmodule

// ==== hw/micro_sequencer.sv ====
`timescale 1ns/1ns

module micro_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  ctrl_pkg::byte_count_t   operand_bytes,
    input  ctrl_pkg::control_word_t rom_word,
    input  isa_pkg::alu_op_t        rom_alu_op,
    input  logic                    rom_halt,
    input  logic                    rom_last,
    input  logic                    branch_skip,
    output ctrl_pkg::microstep_t    microstep,
    output ctrl_pkg::control_word_t control_word,
    output isa_pkg::alu_op_t        alu_op,
    output logic                    last_microstep
);

    ctrl_pkg::seq_state_t  state;
    ctrl_pkg::seq_state_t  next_state;
    ctrl_pkg::byte_count_t byte_count;    // Bytes of the instruction fetched so far
    ctrl_pkg::byte_count_t next_byte_count;
    ctrl_pkg::microstep_t  next_microstep;
    logic latch_alu;

    // ==================================================
    // State registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ctrl_pkg::S_RESET;
            byte_count <= '0;
            microstep  <= '0;
            alu_op     <= isa_pkg::ALU_UNDEFINED;
        end else begin
            state      <= next_state;
            byte_count <= next_byte_count;
            microstep  <= next_microstep;
            if (latch_alu) begin
                alu_op <= rom_alu_op;   // Held for the rest of the instruction
            end
        end
    end

    // ==================================================
    // Next state and control word
    // ==================================================
    always_comb begin
        next_state      = state;
        next_byte_count = byte_count;
        next_microstep  = microstep;
        control_word    = '0;
        last_microstep  = 1'b0;
        latch_alu       = 1'b0;
        case (state)
            ctrl_pkg::S_RESET: next_state = ctrl_pkg::S_INIT;
            ctrl_pkg::S_INIT: begin
                control_word[ctrl_pkg::CW_LOAD_ORIGIN] = 1'b1;
                next_state = ctrl_pkg::S_LATCH_ADDR;
            end
            ctrl_pkg::S_LATCH_ADDR: begin
                control_word[ctrl_pkg::CW_LOAD_MAR_PC] = 1'b1;
                next_state = ctrl_pkg::S_READ_BYTE;
            end
            ctrl_pkg::S_READ_BYTE: begin
                control_word[ctrl_pkg::CW_OE_RAM] = 1'b1;
                next_state = ctrl_pkg::S_LATCH_BYTE;
            end
            ctrl_pkg::S_LATCH_BYTE: begin
                control_word[ctrl_pkg::CW_OE_RAM]      = 1'b1;
                control_word[ctrl_pkg::CW_PC_ENABLE]   = 1'b1;
                control_word[ctrl_pkg::CW_LOAD_IR]     = (byte_count == 2'd0);  // Opcode
                control_word[ctrl_pkg::CW_LOAD_TEMP_1] = (byte_count == 2'd1);
                control_word[ctrl_pkg::CW_LOAD_TEMP_2] = (byte_count == 2'd2);
                next_byte_count = byte_count + 2'd1;
                next_state = ctrl_pkg::S_CHK_MORE_BYTES;
            end
            ctrl_pkg::S_CHK_MORE_BYTES: begin
                if (byte_count > operand_bytes) begin
                    next_byte_count = '0;
                    next_state = ctrl_pkg::S_EXECUTE;
                end else begin
                    next_state = ctrl_pkg::S_LATCH_ADDR;
                end
            end
            ctrl_pkg::S_EXECUTE: begin
                control_word   = rom_word;
                latch_alu      = (microstep == 3'd0) && (rom_alu_op != isa_pkg::ALU_UNDEFINED);
                last_microstep = rom_halt || branch_skip || rom_last;
                next_microstep = '0;
                if (rom_halt) begin
                    next_state = ctrl_pkg::S_HALT;
                end else if (branch_skip) begin
                    // Branch not taken, PC keeps pointing past the operands
                    control_word[ctrl_pkg::CW_LOAD_PC_LOW]  = 1'b0;
                    control_word[ctrl_pkg::CW_LOAD_PC_HIGH] = 1'b0;
                    next_state = ctrl_pkg::S_LATCH_ADDR;
                end else if (rom_last) begin
                    next_state = ctrl_pkg::S_LATCH_ADDR;
                end else begin
                    next_microstep = microstep + 3'd1;
                end
            end
            default: next_state = ctrl_pkg::S_HALT;    // Halted until reset
        endcase
    end

endmodule

// ==== hw/control_unit.sv ====
`timescale 1ns/1ns

module control_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  isa_pkg::opcode_t        opcode,
    input  isa_pkg::flags_t         flags,
    output ctrl_pkg::control_word_t control_word,
    output isa_pkg::alu_op_t        alu_op,
    output logic                    last_microstep
);

    ctrl_pkg::microstep_t    microstep;
    ctrl_pkg::control_word_t rom_word;
    isa_pkg::alu_op_t        rom_alu_op;
    ctrl_pkg::branch_cond_t  rom_cond;
    logic                    rom_halt;
    logic                    rom_last;
    ctrl_pkg::byte_count_t   operand_bytes;
    logic                    branch_skip;

    decode_rom u_decode_rom (
        .opcode        (opcode),
        .microstep     (microstep),
        .rom_word      (rom_word),
        .rom_alu_op    (rom_alu_op),
        .rom_cond      (rom_cond),
        .rom_halt      (rom_halt),
        .rom_last      (rom_last),
        .operand_bytes (operand_bytes)
    );

    branch_eval u_branch_eval (
        .cond        (rom_cond),
        .flags       (flags),
        .branch_skip (branch_skip)
    );

    micro_sequencer u_micro_sequencer (
        .clk            (clk),
        .reset          (reset),
        .operand_bytes  (operand_bytes),
        .rom_word       (rom_word),
        .rom_alu_op     (rom_alu_op),
        .rom_halt       (rom_halt),
        .rom_last       (rom_last),
        .branch_skip    (branch_skip),
        .microstep      (microstep),
        .control_word   (control_word),
        .alu_op         (alu_op),
        .last_microstep (last_microstep)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    input  logic restart,    // Pulse to hold reset again
    output logic clk,
    output logic reset
);

    int reset_count;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset       = 1'b1;
        reset_count = RESET_CYCLES;
    end

    always @(posedge clk) begin
        if (restart) begin
            reset       <= 1'b1;
            reset_count <= RESET_CYCLES;
        end else if (reset_count > 1) begin
            reset_count <= reset_count - 1;
        end else begin
            reset       <= 1'b0;    // Released after the last counted edge
            reset_count <= 0;
        end
    end

endmodule

// ==== verif/cu_model.svh ====
`ifndef CU_MODEL_SVH
`define CU_MODEL_SVH

// ==================================================
// Instruction table
// ==================================================
// Operand bytes, execute steps, ALU operation, branch condition, halt
task automatic lookup_instr(
    input  isa_pkg::opcode_t       op,
    output int                     n_ops,
    output int                     n_steps,
    output isa_pkg::alu_op_t       alu,
    output ctrl_pkg::branch_cond_t cond,
    output logic                   halts
);
    n_steps = 2;    // Jumps and most ALU instructions
    alu     = isa_pkg::ALU_UNDEFINED;
    halts   = 1'b0;
    case (op)
        isa_pkg::ADD_B: begin
            n_steps = 3;
            alu     = isa_pkg::ALU_ADD;
        end
        isa_pkg::ADD_C: alu = isa_pkg::ALU_ADD;
        isa_pkg::ADC_B, isa_pkg::ADC_C: alu = isa_pkg::ALU_ADC;
        isa_pkg::SUB_B, isa_pkg::SUB_C,
        isa_pkg::CMP_B, isa_pkg::CMP_C: alu = isa_pkg::ALU_SUB;  // Compare subtracts
        isa_pkg::SBC_B, isa_pkg::SBC_C: alu = isa_pkg::ALU_SBC;
        isa_pkg::INR_A, isa_pkg::INR_B, isa_pkg::INR_C: alu = isa_pkg::ALU_INR;
        isa_pkg::DCR_A, isa_pkg::DCR_B, isa_pkg::DCR_C: alu = isa_pkg::ALU_DCR;
        isa_pkg::ANA_B, isa_pkg::ANA_C, isa_pkg::ANI: alu = isa_pkg::ALU_AND;
        isa_pkg::ORA_B, isa_pkg::ORA_C, isa_pkg::ORI: alu = isa_pkg::ALU_OR;
        isa_pkg::XRA_B, isa_pkg::XRA_C, isa_pkg::XRI: alu = isa_pkg::ALU_XOR;
        isa_pkg::JMP, isa_pkg::JZ, isa_pkg::JNZ, isa_pkg::JC,
        isa_pkg::JNC, isa_pkg::JN, isa_pkg::JNN: n_steps = 2;
        isa_pkg::LDA, isa_pkg::STA: n_steps = 6;
        isa_pkg::NOP, isa_pkg::MOV_AB, isa_pkg::MOV_AC, isa_pkg::MOV_BA,
        isa_pkg::MOV_BC, isa_pkg::MOV_CA, isa_pkg::MOV_CB,
        isa_pkg::LDI_A, isa_pkg::LDI_B, isa_pkg::LDI_C,
        isa_pkg::SEC, isa_pkg::CLC: n_steps = 1;
        default: begin
            n_steps = 1;    // HLT and anything outside the table
            halts   = 1'b1;
        end
    endcase
    case (op)
        isa_pkg::ANI, isa_pkg::ORI, isa_pkg::XRI,
        isa_pkg::LDI_A, isa_pkg::LDI_B, isa_pkg::LDI_C: n_ops = 1;
        isa_pkg::JMP, isa_pkg::JZ, isa_pkg::JNZ, isa_pkg::JC, isa_pkg::JNC,
        isa_pkg::JN, isa_pkg::JNN, isa_pkg::LDA, isa_pkg::STA: n_ops = 2;
        default: n_ops = 0;
    endcase
    case (op)
        isa_pkg::JZ:  cond = ctrl_pkg::COND_ZERO;
        isa_pkg::JNZ: cond = ctrl_pkg::COND_NOT_ZERO;
        isa_pkg::JC:  cond = ctrl_pkg::COND_CARRY;
        isa_pkg::JNC: cond = ctrl_pkg::COND_NOT_CARRY;
        isa_pkg::JN:  cond = ctrl_pkg::COND_NEG;
        isa_pkg::JNN: cond = ctrl_pkg::COND_NOT_NEG;
        default:      cond = ctrl_pkg::COND_NONE;
    endcase
endtask

// True when the jump is taken
function automatic logic cond_holds(
    input ctrl_pkg::branch_cond_t cond,
    input isa_pkg::flags_t        fl
);
    case (cond)
        ctrl_pkg::COND_ZERO:      return fl[isa_pkg::FLAG_ZERO];
        ctrl_pkg::COND_NOT_ZERO:  return !fl[isa_pkg::FLAG_ZERO];
        ctrl_pkg::COND_CARRY:     return fl[isa_pkg::FLAG_CARRY];
        ctrl_pkg::COND_NOT_CARRY: return !fl[isa_pkg::FLAG_CARRY];
        ctrl_pkg::COND_NEG:       return fl[isa_pkg::FLAG_NEG];
        ctrl_pkg::COND_NOT_NEG:   return !fl[isa_pkg::FLAG_NEG];
        default:                  return 1'b1;
    endcase
endfunction

`endif

// ==== verif/control_unit_tb.sv ====
`timescale 1ns/1ns

module control_unit_tb;

    localparam int NUM_INSTR   = 300;
    localparam int HALT_CYCLES = 20;
    localparam int WAIT_LIMIT  = 32;    // Cycles allowed for any single wait

    logic                    clk;
    logic                    reset;
    logic                    restart;
    isa_pkg::opcode_t        opcode;
    isa_pkg::flags_t         flags;
    ctrl_pkg::control_word_t control_word;
    isa_pkg::alu_op_t        alu_op;
    logic                    last_microstep;

    logic [31:0]      lfsr_state;
    isa_pkg::alu_op_t prev_alu;    // What alu_op should hold now
    int               error_count;
    int               instr_count;
    logic             halted;

    tb_clock_gen clock_gen (.restart(restart), .clk(clk), .reset(reset));

    control_unit dut (
        .clk            (clk),
        .reset          (reset),
        .opcode         (opcode),
        .flags          (flags),
        .control_word   (control_word),
        .alu_op         (alu_op),
        .last_microstep (last_microstep)
    );

    `include "cu_model.svh"

    // ==================================================
    // Error reporting and compares
    // ==================================================
    task automatic stop_on_error(input string reason);
        error_count++;
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_word(input string name, input ctrl_pkg::control_word_t got,
                              input ctrl_pkg::control_word_t exp);
        if (got !== exp) stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_alu(input string name, input isa_pkg::alu_op_t got,
                             input isa_pkg::alu_op_t exp);
        if (got !== exp) stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    // ==================================================
    // Stimulus helpers
    // ==================================================
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = galois_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic ctrl_pkg::control_word_t one_hot_word(input int pos);
        ctrl_pkg::control_word_t w;
        w      = '0;
        w[pos] = 1'b1;
        return w;
    endfunction

    function automatic int fetch_load_bit(input int byte_idx);
        case (byte_idx)
            0:       return ctrl_pkg::CW_LOAD_IR;
            1:       return ctrl_pkg::CW_LOAD_TEMP_1;
            default: return ctrl_pkg::CW_LOAD_TEMP_2;
        endcase
    endfunction

    task automatic pick_instruction(output isa_pkg::opcode_t op, output isa_pkg::flags_t fl);
        logic [31:0] r;
        take_bits(5, r);
        if (r == 0) begin               // About one in 32 stops the machine
            take_bits(1, r);
            if (r[0]) begin
                op = isa_pkg::HLT;
            end else begin
                take_bits(8, r);
                op = (r[7:0] > isa_pkg::STA) ? r[7:0] : (8'hC0 | r[7:0]);
            end
        end else begin
            op = isa_pkg::HLT;
            while (op == isa_pkg::HLT || op > isa_pkg::STA) begin
                take_bits(6, r);
                op = {2'b00, r[5:0]};
            end
        end
        take_bits(3, r);
        fl = r[2:0];
    endtask

    // ==================================================
    // Waits and checked sequences
    // ==================================================
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (reset) begin
            if (cycles >= WAIT_LIMIT) stop_on_error("Timed out waiting for reset to drop");
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic check_fetch_cycle(input ctrl_pkg::control_word_t exp);
        check_word("control_word", control_word, exp);
        check_bit("last_microstep", last_microstep, 1'b0);
    endtask

    task automatic run_reset_checks();
        wait_reset_release();
        prev_alu = isa_pkg::ALU_UNDEFINED;
        check_word("control_word", control_word, '0);
        check_alu("alu_op", alu_op, isa_pkg::ALU_UNDEFINED);
        check_bit("last_microstep", last_microstep, 1'b0);
        @(negedge clk);
        check_word("control_word", control_word, one_hot_word(ctrl_pkg::CW_LOAD_ORIGIN));
        @(negedge clk);    // First fetch cycle
    endtask

    task automatic run_instruction(output logic halts);
        isa_pkg::opcode_t        op;
        isa_pkg::flags_t         fl;
        isa_pkg::alu_op_t        exp_alu;
        ctrl_pkg::branch_cond_t  cond;
        ctrl_pkg::control_word_t latch_word;
        int                      n_ops;
        int                      n_steps;
        int                      exp_steps;
        int                      byte_idx;
        int                      step;
        logic                    is_jump;
        logic                    taken;
        byte_idx = 0;
        n_ops    = 0;
        while (byte_idx <= n_ops) begin    // Four cycles per byte
            if (byte_idx > 0) @(negedge clk);
            check_fetch_cycle(one_hot_word(ctrl_pkg::CW_LOAD_MAR_PC));
            @(negedge clk);
            check_fetch_cycle(one_hot_word(ctrl_pkg::CW_OE_RAM));
            @(negedge clk);
            latch_word = one_hot_word(ctrl_pkg::CW_OE_RAM) | one_hot_word(ctrl_pkg::CW_PC_ENABLE)
                       | one_hot_word(fetch_load_bit(byte_idx));
            check_fetch_cycle(latch_word);
            if (byte_idx == 0) begin
                pick_instruction(op, fl);
                lookup_instr(op, n_ops, n_steps, exp_alu, cond, halts);
                @(posedge clk);
                opcode <= op;    // IR output of the datapath
                flags  <= fl;
            end
            @(negedge clk);
            check_fetch_cycle('0);
            byte_idx++;
        end

        is_jump   = op inside {isa_pkg::JMP, isa_pkg::JZ, isa_pkg::JNZ, isa_pkg::JC,
                               isa_pkg::JNC, isa_pkg::JN, isa_pkg::JNN};
        taken     = cond_holds(cond, fl);
        exp_steps = (is_jump && !taken) ? 1 : n_steps;
        if (exp_alu != isa_pkg::ALU_UNDEFINED) prev_alu = exp_alu;
        step = 0;
        @(negedge clk);
        check_bit("load_mar_pc", control_word[ctrl_pkg::CW_LOAD_MAR_PC], 1'b0);
        forever begin
            check_bit("last_microstep", last_microstep, step == exp_steps - 1);
            if (is_jump && step == 0) begin
                check_bit("load_pc_low", control_word[ctrl_pkg::CW_LOAD_PC_LOW], taken);
                check_bit("load_pc_high", control_word[ctrl_pkg::CW_LOAD_PC_HIGH], 1'b0);
            end
            if (is_jump && step == 1) begin
                check_bit("load_pc_high", control_word[ctrl_pkg::CW_LOAD_PC_HIGH], 1'b1);
            end
            if (last_microstep) break;
            step++;
            if (step >= WAIT_LIMIT) stop_on_error("Timed out waiting for last_microstep");
            @(negedge clk);
        end
        @(negedge clk);
        check_alu("alu_op", alu_op, prev_alu);
    endtask

    task automatic check_halt_window();
        for (int i = 0; i < HALT_CYCLES; i++) begin
            if (i > 0) @(negedge clk);
            check_word("control_word", control_word, '0);
            check_bit("last_microstep", last_microstep, 1'b0);
        end
    endtask

    task automatic restart_dut();
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        lfsr_state  = 32'had33c7e0;
        opcode      = isa_pkg::NOP;
        flags       = '0;
        restart     = 1'b0;
        error_count = 0;
        instr_count = 0;
        prev_alu    = isa_pkg::ALU_UNDEFINED;
        run_reset_checks();
        while (instr_count < NUM_INSTR) begin
            run_instruction(halted);
            instr_count++;
            if (halted) begin          // Restart the stopped machine
                check_halt_window();
                restart_dut();
                run_reset_checks();
            end
        end
        if (error_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_on_error("Errors were counted during the run");
        end
    end

endmodule

// ==== build.f ====
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/decode_rom.sv
hw/branch_eval.sv
hw/micro_sequencer.sv
hw/control_unit.sv
+incdir+verif
verif/tb_clock_gen.sv
verif/control_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= control_unit_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF -- "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
